// File: axi_single_master.sv
`timescale 1ns/1ps

module axi_single_master (
    input  logic                     aclk,
    input  logic                     rst_n,

    input  mem_pkg::xlat_req_t       issue_req,
    input  logic                     issue_busy,
    output logic                     issue_done,
    output logic                     done_src,
    output logic [31:0]              done_rdata,

    output logic [mem_pkg::ID_W-1:0] m_arid,
    output logic [31:0]              m_araddr,
    output logic [2:0]               m_arsize,
    output logic [3:0]               m_arcache,
    output logic                     m_arvalid,
    input  logic                     m_arready,
    input  logic [mem_pkg::ID_W-1:0] m_rid,
    input  logic [31:0]              m_rdata,
    input  logic                     m_rvalid,
    output logic                     m_rready,

    output logic [mem_pkg::ID_W-1:0] m_awid,
    output logic [31:0]              m_awaddr,
    output logic [2:0]               m_awsize,
    output logic [3:0]               m_awcache,
    output logic                     m_awvalid,
    input  logic                     m_awready,
    output logic [31:0]              m_wdata,
    output logic [3:0]               m_wstrb,
    output logic                     m_wlast,
    output logic                     m_wvalid,
    input  logic                     m_wready,
    input  logic                     m_bvalid,
    output logic                     m_bready
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_ADDR,
        S_RD_DATA,
        S_WR,
        S_WR_RESP,
        S_DONE
    } state_t;

    state_t                   state;
    logic [mem_pkg::ID_W-1:0] cur_id;
    logic [3:0]               cur_cache;
    logic [1:0]               lane;
    logic [3:0]               size_mask;
    logic [31:0]              rd_shift;
    logic [31:0]              rd_lane;
    logic                     r_hit;
    logic                     aw_ok;
    logic                     w_ok;

    assign cur_id    = {{(mem_pkg::ID_W-1){1'b0}}, issue_req.src};
    assign cur_cache = issue_req.cached ? mem_pkg::CACHE_ATTR_CACHED
                                        : mem_pkg::CACHE_ATTR_UNCACHED;

    // Byte lane offset and strobe pattern from size and low address bits
    always_comb begin
        case (issue_req.size)
            mem_pkg::SIZE_BYTE: begin
                lane      = issue_req.paddr[1:0];
                size_mask = 4'b0001;
            end
            mem_pkg::SIZE_HALF: begin
                lane      = {issue_req.paddr[1], 1'b0};
                size_mask = 4'b0011;
            end
            default: begin
                lane      = 2'd0;
                size_mask = 4'b1111;
            end
        endcase
    end

    assign rd_shift = m_rdata >> {lane, 3'b000};

    always_comb begin
        case (issue_req.size)
            mem_pkg::SIZE_BYTE: rd_lane = {24'h0, rd_shift[7:0]};
            mem_pkg::SIZE_HALF: rd_lane = {16'h0, rd_shift[15:0]};
            default:            rd_lane = rd_shift;
        endcase
    end

    assign r_hit = m_rvalid && (m_rid == cur_id);   // Only one read outstanding
    assign aw_ok = !m_awvalid || m_awready;
    assign w_ok  = !m_wvalid || m_wready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            m_arvalid <= 1'b0;
            m_awvalid <= 1'b0;
            m_wvalid  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (issue_busy) begin
                        if (issue_req.write) begin
                            m_awvalid <= 1'b1;   // AW and W go up together
                            m_wvalid  <= 1'b1;
                            state     <= S_WR;
                        end else begin
                            m_arvalid <= 1'b1;
                            state     <= S_RD_ADDR;
                        end
                    end
                end
                S_RD_ADDR: begin
                    if (m_arready) begin
                        m_arvalid <= 1'b0;
                        state     <= S_RD_DATA;
                    end
                end
                S_RD_DATA: begin
                    if (r_hit)
                        state <= S_DONE;
                end
                S_WR: begin
                    if (m_awready)
                        m_awvalid <= 1'b0;
                    if (m_wready)
                        m_wvalid <= 1'b0;
                    if (aw_ok && w_ok)
                        state <= S_WR_RESP;
                end
                S_WR_RESP: begin
                    if (m_bvalid)
                        state <= S_DONE;
                end
                S_DONE:  state <= S_IDLE;   // Arbiter drops busy on this edge
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == S_RD_DATA && r_hit)
            done_rdata <= rd_lane;
        else if (state == S_WR_RESP && m_bvalid)
            done_rdata <= 32'h0;
    end

    assign issue_done = (state == S_DONE);
    assign done_src   = issue_req.src;

    assign m_arid    = cur_id;
    assign m_araddr  = issue_req.paddr;
    assign m_arsize  = {1'b0, issue_req.size};
    assign m_arcache = cur_cache;
    assign m_rready  = 1'b1;

    assign m_awid    = cur_id;
    assign m_awaddr  = issue_req.paddr;
    assign m_awsize  = {1'b0, issue_req.size};
    assign m_awcache = cur_cache;
    assign m_wdata   = issue_req.wdata << {lane, 3'b000};   // Core data is right aligned
    assign m_wstrb   = size_mask << lane;
    assign m_wlast   = 1'b1;   // Single beat
    assign m_bready  = 1'b1;

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic               aclk,
    input  logic               rst_n,

    input  mem_pkg::xlat_req_t inst_xreq,
    input  mem_pkg::xlat_req_t data_xreq,
    input  logic               inst_pending,
    input  logic               data_pending,
    output logic               inst_take,
    output logic               data_take,

    output mem_pkg::xlat_req_t issue_req,
    output logic               issue_busy,
    input  logic               issue_done
);

    logic free;
    logic grant;

    assign free = !issue_busy;

    // Data side always wins, fetch only gets an idle data slot
    assign data_take = free && data_pending;
    assign inst_take = free && inst_pending && !data_pending;
    assign grant     = data_take || inst_take;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            issue_busy <= 1'b0;
        end else if (issue_done) begin
            issue_busy <= 1'b0;
        end else if (grant) begin
            issue_busy <= 1'b1;
        end
    end

    // Held stable for the AXI stage until the done pulse
    always_ff @(posedge aclk) begin
        if (data_take)
            issue_req <= data_xreq;
        else if (inst_take)
            issue_req <= inst_xreq;
    end

endmodule

// File: list.f
mem_pkg.sv
seg_translate.sv
bus_arbiter.sv
axi_single_master.sv
mem_subsys_top.sv
tb_checker.sv
tb_top.sv

// File: mem_pkg.sv
package mem_pkg;

    // AXI ID width, the source sits in bit 0
    localparam int ID_W = 4;

    localparam logic SRC_INST = 1'b0;
    localparam logic SRC_DATA = 1'b1;

    // AXI size codes, the upper bit of AxSIZE is always zero here
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    localparam logic [2:0] SEG_KSEG1 = 3'b101;   // Unmapped, uncached

    localparam logic [3:0] CACHE_ATTR_CACHED   = 4'b1111;
    localparam logic [3:0] CACHE_ATTR_UNCACHED = 4'b0000;

    // Request as presented by the core, virtual address
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  size;
    } core_req_t;

    // Request after segment translation
    typedef struct packed {
        logic        write;
        logic [31:0] paddr;
        logic [31:0] wdata;
        logic [1:0]  size;
        logic        cached;
        logic        src;      // SRC_INST or SRC_DATA
    } xlat_req_t;

endpackage

// File: mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                     aclk,
    input  logic                     rst_n,

    input  logic                     inst_en,
    input  logic [31:0]              inst_addr,
    output logic [31:0]              inst_rdata,
    output logic                     inst_stall,

    input  logic                     data_en,
    input  logic                     data_wr,
    input  logic [31:0]              data_addr,
    input  logic [31:0]              data_wdata,
    input  logic [1:0]               data_size,
    output logic [31:0]              data_rdata,
    output logic                     data_stall,

    output logic [mem_pkg::ID_W-1:0] m_arid,
    output logic [31:0]              m_araddr,
    output logic [2:0]               m_arsize,
    output logic [3:0]               m_arcache,
    output logic                     m_arvalid,
    input  logic                     m_arready,
    input  logic [mem_pkg::ID_W-1:0] m_rid,
    input  logic [31:0]              m_rdata,
    input  logic                     m_rvalid,
    output logic                     m_rready,
    output logic [mem_pkg::ID_W-1:0] m_awid,
    output logic [31:0]              m_awaddr,
    output logic [2:0]               m_awsize,
    output logic [3:0]               m_awcache,
    output logic                     m_awvalid,
    input  logic                     m_awready,
    output logic [31:0]              m_wdata,
    output logic [3:0]               m_wstrb,
    output logic                     m_wlast,
    output logic                     m_wvalid,
    input  logic                     m_wready,
    input  logic                     m_bvalid,
    output logic                     m_bready
);

    mem_pkg::core_req_t data_req;
    mem_pkg::xlat_req_t inst_xreq;
    mem_pkg::xlat_req_t data_xreq;
    mem_pkg::xlat_req_t issue_req;
    logic               inst_pending;
    logic               data_pending;
    logic               inst_take;
    logic               data_take;
    logic               issue_busy;
    logic               issue_done;
    logic               done_src;
    logic [31:0]        done_rdata;

    assign data_req = '{write: data_wr, addr: data_addr, wdata: data_wdata, size: data_size};

    seg_translate u_xlat (
        .aclk         (aclk        ),
        .rst_n        (rst_n       ),
        .inst_en      (inst_en     ),
        .inst_addr    (inst_addr   ),
        .inst_rdata   (inst_rdata  ),
        .inst_stall   (inst_stall  ),
        .data_en      (data_en     ),
        .data_req     (data_req    ),
        .data_rdata   (data_rdata  ),
        .data_stall   (data_stall  ),
        .inst_xreq    (inst_xreq   ),
        .data_xreq    (data_xreq   ),
        .inst_pending (inst_pending),
        .data_pending (data_pending),
        .inst_take    (inst_take   ),
        .data_take    (data_take   ),
        .resp_done    (issue_done  ),
        .resp_src     (done_src    ),
        .resp_rdata   (done_rdata  )
    );

    bus_arbiter u_arb (
        .aclk         (aclk        ),
        .rst_n        (rst_n       ),
        .inst_xreq    (inst_xreq   ),
        .data_xreq    (data_xreq   ),
        .inst_pending (inst_pending),
        .data_pending (data_pending),
        .inst_take    (inst_take   ),
        .data_take    (data_take   ),
        .issue_req    (issue_req   ),
        .issue_busy   (issue_busy  ),
        .issue_done   (issue_done  )
    );

    axi_single_master u_axi (
        .aclk       (aclk      ),
        .rst_n      (rst_n     ),
        .issue_req  (issue_req ),
        .issue_busy (issue_busy),
        .issue_done (issue_done),
        .done_src   (done_src  ),
        .done_rdata (done_rdata),
        .m_arid     (m_arid    ),
        .m_araddr   (m_araddr  ),
        .m_arsize   (m_arsize  ),
        .m_arcache  (m_arcache ),
        .m_arvalid  (m_arvalid ),
        .m_arready  (m_arready ),
        .m_rid      (m_rid     ),
        .m_rdata    (m_rdata   ),
        .m_rvalid   (m_rvalid  ),
        .m_rready   (m_rready  ),
        .m_awid     (m_awid    ),
        .m_awaddr   (m_awaddr  ),
        .m_awsize   (m_awsize  ),
        .m_awcache  (m_awcache ),
        .m_awvalid  (m_awvalid ),
        .m_awready  (m_awready ),
        .m_wdata    (m_wdata   ),
        .m_wstrb    (m_wstrb   ),
        .m_wlast    (m_wlast   ),
        .m_wvalid   (m_wvalid  ),
        .m_wready   (m_wready  ),
        .m_bvalid   (m_bvalid  ),
        .m_bready   (m_bready  )
    );

endmodule

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator, pass only if TEST OK is printed
cd "$(dirname "$0")" &&
    verilator --binary --timing -f list.f --top-module tb_top -o sim_tb &&
    ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST OK" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

// File: seg_translate.sv
`timescale 1ns/1ps

module seg_translate (
    input  logic               aclk,
    input  logic               rst_n,

    input  logic               inst_en,
    input  logic [31:0]        inst_addr,
    output logic [31:0]        inst_rdata,
    output logic               inst_stall,

    input  logic               data_en,
    input  mem_pkg::core_req_t data_req,
    output logic [31:0]        data_rdata,
    output logic               data_stall,

    output mem_pkg::xlat_req_t inst_xreq,
    output mem_pkg::xlat_req_t data_xreq,
    output logic               inst_pending,
    output logic               data_pending,
    input  logic               inst_take,
    input  logic               data_take,

    input  logic               resp_done,
    input  logic               resp_src,
    input  logic [31:0]        resp_rdata
);

    mem_pkg::core_req_t port_req [2];
    mem_pkg::xlat_req_t slot_req [2];
    logic [31:0]        rdata_q  [2];
    logic [1:0]         port_en;
    logic [1:0]         take;
    logic [1:0]         pending;
    logic [1:0]         inflight;
    logic [1:0]         capture;
    logic [1:0]         resp_hit;

    function automatic mem_pkg::xlat_req_t translate(input mem_pkg::core_req_t req,
                                                     input logic src);
        mem_pkg::xlat_req_t x;
        x.write  = req.write;
        x.paddr  = {3'b000, req.addr[28:0]};   // kseg0/kseg1 map onto the low 512 MB
        x.wdata  = req.wdata;
        x.size   = req.size;
        x.cached = (req.addr[31:29] != mem_pkg::SEG_KSEG1);
        x.src    = src;
        return x;
    endfunction

    always_comb begin
        // Fetch port only ever reads whole words
        port_req[mem_pkg::SRC_INST] = '{write: 1'b0, addr: inst_addr,
                                        wdata: 32'h0, size: mem_pkg::SIZE_WORD};
        port_req[mem_pkg::SRC_DATA] = data_req;
        port_en[mem_pkg::SRC_INST]  = inst_en;
        port_en[mem_pkg::SRC_DATA]  = data_en;
        take[mem_pkg::SRC_INST]     = inst_take;
        take[mem_pkg::SRC_DATA]     = data_take;
        resp_hit[mem_pkg::SRC_INST] = resp_done && (resp_src == mem_pkg::SRC_INST);
        resp_hit[mem_pkg::SRC_DATA] = resp_done && (resp_src == mem_pkg::SRC_DATA);
    end

    assign capture = port_en & ~pending & ~inflight;   // Slot empty and core asking

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= '0;
            inflight <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (capture[p]) begin
                    pending[p] <= 1'b1;
                end else if (take[p]) begin
                    pending[p]  <= 1'b0;
                    inflight[p] <= 1'b1;
                end else if (resp_hit[p]) begin
                    inflight[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int p = 0; p < 2; p++) begin
            if (capture[p])
                slot_req[p] <= translate(port_req[p], 1'(p));
            if (resp_hit[p])
                rdata_q[p] <= resp_rdata;   // Keep last word visible to the core
        end
    end

    assign inst_xreq    = slot_req[mem_pkg::SRC_INST];
    assign data_xreq    = slot_req[mem_pkg::SRC_DATA];
    assign inst_pending = pending[mem_pkg::SRC_INST];
    assign data_pending = pending[mem_pkg::SRC_DATA];

    // Stall drops only in the response cycle
    assign inst_stall = inst_en && !resp_hit[mem_pkg::SRC_INST];
    assign data_stall = data_en && !resp_hit[mem_pkg::SRC_DATA];
    assign inst_rdata = resp_hit[mem_pkg::SRC_INST] ? resp_rdata : rdata_q[mem_pkg::SRC_INST];
    assign data_rdata = resp_hit[mem_pkg::SRC_DATA] ? resp_rdata : rdata_q[mem_pkg::SRC_DATA];

endmodule

// File: stim.txt
# name port(i/d) write size(0 byte,1 half,2 word) vaddr wdata expected_rdata cached pair
# pair 1 starts this record in the same cycle as the next one
kseg1_rd_word    d 0 2 A0001000 00000000 FFFFEFFF 0 0
kseg0_rd_word    d 0 2 80002004 00000000 FFFFDFFB 1 0
ifetch_kseg0     i 0 2 80000100 00000000 FFFFFEFF 1 0
ifetch_kseg1     i 0 2 BFC00000 00000000 E03FFFFF 0 0
st_byte0         d 1 0 80003000 000000A5 00000000 1 0
st_byte3         d 1 0 80003003 0000005A 00000000 1 0
rd_merge_bytes   d 0 2 80003000 00000000 5AFFCFA5 1 0
st_half0         d 1 1 A0004000 00001234 00000000 0 0
st_half2         d 1 1 A0004002 0000ABCD 00000000 0 0
rd_merge_halves  d 0 2 A0004000 00000000 ABCD1234 0 0
ld_byte1         d 0 0 80003001 00000000 000000CF 1 0
ld_byte3         d 0 0 80003003 00000000 0000005A 1 0
ld_half2         d 0 1 A0004002 00000000 0000ABCD 0 0
ld_half0_fresh   d 0 1 80005000 00000000 0000AFFF 1 0
ld_byte1_fresh   d 0 0 80006001 00000000 0000009F 1 0
pair_fetch_a     i 0 2 80007000 00000000 FFFF8FFF 1 1
pair_load_a      d 0 2 A0008000 00000000 FFFF7FFF 0 0
pair_fetch_b     i 0 2 80000100 00000000 FFFFFEFF 1 1
pair_store_b     d 1 2 80009000 11223344 00000000 1 0
rd_word_stored   d 0 2 80009000 00000000 11223344 1 0
ifetch_stored    i 0 2 A0009000 00000000 11223344 0 0

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic        aclk,
    input  logic        rst_n,
    input  logic        inst_en,
    input  logic        inst_stall,
    input  logic [31:0] inst_rdata,
    input  logic        data_en,
    input  logic        data_stall,
    input  logic [31:0] data_rdata,
    input  logic [3:0]  m_arid,
    input  logic [31:0] m_araddr,
    input  logic [2:0]  m_arsize,
    input  logic [3:0]  m_arcache,
    input  logic        m_arvalid,
    input  logic        m_arready,
    input  logic        m_rvalid,
    input  logic        m_rready,
    input  logic [3:0]  m_awid,
    input  logic [31:0] m_awaddr,
    input  logic [2:0]  m_awsize,
    input  logic [3:0]  m_awcache,
    input  logic        m_awvalid,
    input  logic        m_awready,
    input  logic [31:0] m_wdata,
    input  logic [3:0]  m_wstrb,
    input  logic        m_wlast,
    input  logic        m_wvalid,
    input  logic        m_wready,
    input  logic        m_bvalid,
    input  logic        m_bready,
    output int          pass_cnt,
    output int          fail_cnt,
    output int          proto_err
);

    // One outstanding expectation per core port (0 fetch, 1 data)
    logic        active   [2];
    logic        seen     [2];
    string       name     [2];
    logic        is_wr    [2];
    logic [1:0]  size     [2];
    logic [31:0] vaddr    [2];
    logic [31:0] wdata    [2];
    logic [31:0] exp_rd   [2];
    logic        exp_cach [2];
    logic        err      [2];
    string       err_what [2];
    logic [31:0] err_exp  [2];
    logic [31:0] err_act  [2];

    initial begin
        pass_cnt  = 0;
        fail_cnt  = 0;
        proto_err = 0;
        for (int p = 0; p < 2; p++) begin
            active[p] = 1'b0;
            seen[p]   = 1'b0;
        end
    end

    task automatic expect_req(input int p, input string n, input logic wr, input logic [1:0] sz,
                              input logic [31:0] va, input logic [31:0] wd,
                              input logic [31:0] rd, input logic cached);
        active[p]   = 1'b1;
        seen[p]     = 1'b0;
        err[p]      = 1'b0;
        name[p]     = n;
        is_wr[p]    = wr;
        size[p]     = sz;
        vaddr[p]    = va;
        wdata[p]    = wd;
        exp_rd[p]   = rd;
        exp_cach[p] = cached;
    endtask

    // First mismatch of a test is the one reported
    task automatic note(input int p, input string what, input logic [31:0] e,
                        input logic [31:0] a);
        if (!err[p]) begin
            err_what[p] = what;
            err_exp[p]  = e;
            err_act[p]  = a;
        end
        err[p] = 1'b1;
    endtask

    function automatic logic [3:0] lane_strobe(input logic [1:0] sz, input logic [1:0] off);
        int          o;
        int          nbytes;
        logic [3:0]  s;
        o      = int'(off);
        nbytes = 1 << sz;
        s      = 4'b0000;
        for (int b = 0; b < 4; b++) begin
            if (b >= o && b < o + nbytes)
                s[b] = 1'b1;
        end
        return s;
    endfunction

    task automatic check_addr(input int p, input logic wr, input logic [31:0] addr,
                              input logic [3:0] cache, input logic [3:0] id,
                              input logic [2:0] asize, input string chan);
        if (!active[p] || seen[p]) begin
            $display("Address on %s for a port with no request outstanding", chan);
            proto_err++;
        end else begin
            // Data must reach the bus first when both ports wait
            if (active[0] && active[1] && !seen[0] && !seen[1] && p == 0)
                note(p, "bus order", 32'd1, 32'd0);
            if (is_wr[p] != wr)
                note(p, "direction", 32'(is_wr[p]), 32'(wr));
            if (id != 4'(p))
                note(p, "id", 32'(p), 32'(id));
            if (asize != {1'b0, size[p]})
                note(p, "size", 32'(size[p]), 32'(asize));
            if (addr != (vaddr[p] & 32'h1fff_ffff))
                note(p, "address", vaddr[p] & 32'h1fff_ffff, addr);
            if (cache != (exp_cach[p] ? 4'b1111 : 4'b0000))
                note(p, "cache", exp_cach[p] ? 32'hf : 32'h0, 32'(cache));
            seen[p] = 1'b1;
        end
    endtask

    task automatic check_wbeat();
        logic [3:0]  s;
        logic [31:0] e;
        logic [31:0] mask;
        int          o;
        s    = lane_strobe(size[1], vaddr[1][1:0]);
        o    = int'(vaddr[1][1:0]);
        e    = 32'h0;
        mask = 32'h0;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                e[8*b +: 8]    = wdata[1][8*(b-o) +: 8];
                mask[8*b +: 8] = 8'hff;
            end
        end
        if (!active[1] || !is_wr[1]) begin
            $display("Write data beat with no store outstanding");
            proto_err++;
        end else if (!m_wlast) begin
            note(1, "wlast", 32'd1, 32'd0);
        end else if (m_wstrb != s) begin
            note(1, "wstrb", 32'(s), 32'(m_wstrb));
        end else if (((m_wdata ^ e) & mask) != 32'h0) begin
            note(1, "wdata", e, m_wdata & mask);
        end
    endtask

    task automatic finish_test(input int p, input logic [31:0] rdata);
        if (!active[p]) begin
            $display("Stall dropped on port %0d with nothing outstanding", p);
            proto_err++;
        end else begin
            if (!seen[p])
                note(p, "response before bus", 32'd1, 32'd0);
            if (!is_wr[p] && rdata != exp_rd[p])
                note(p, "rdata", exp_rd[p], rdata);
            if (err[p]) begin
                $display("FAILED %s %s expected %h actual %h",
                         name[p], err_what[p], err_exp[p], err_act[p]);
                fail_cnt++;
            end else begin
                $display("PASSED %s", name[p]);
                pass_cnt++;
            end
            active[p] = 1'b0;
        end
    endtask

    always @(posedge aclk) begin
        if (rst_n) begin
            if (m_arvalid && m_arready)
                check_addr(int'(m_arid[0]), 1'b0, m_araddr, m_arcache, m_arid, m_arsize, "AR");
            if (m_awvalid && m_awready)
                check_addr(int'(m_awid[0]), 1'b1, m_awaddr, m_awcache, m_awid, m_awsize, "AW");
            if (m_wvalid && m_wready)
                check_wbeat();
            if (m_rvalid && !m_rready) begin
                $display("Read data offered while rready was low");
                proto_err++;
            end
            if (m_bvalid && !m_bready) begin
                $display("Write response offered while bready was low");
                proto_err++;
            end
            if (inst_en && !inst_stall)
                finish_test(0, inst_rdata);
            if (data_en && !data_stall)
                finish_test(1, data_rdata);
        end
    end

    task automatic summary();
        $display("Tests: %0d passed, %0d failed, %0d protocol errors",
                 pass_cnt, fail_cnt, proto_err);
    endtask

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

    logic        aclk;
    logic        rst_n;
    logic        inst_en;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_stall;
    logic        data_en;
    logic        data_wr;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [1:0]  data_size;
    logic [31:0] data_rdata;
    logic        data_stall;
    logic [3:0]  m_arid;
    logic [31:0] m_araddr;
    logic [2:0]  m_arsize;
    logic [3:0]  m_arcache;
    logic        m_arvalid;
    logic        m_arready;
    logic [3:0]  m_rid;
    logic [31:0] m_rdata;
    logic        m_rvalid;
    logic        m_rready;
    logic [3:0]  m_awid;
    logic [31:0] m_awaddr;
    logic [2:0]  m_awsize;
    logic [3:0]  m_awcache;
    logic        m_awvalid;
    logic        m_awready;
    logic [31:0] m_wdata;
    logic [3:0]  m_wstrb;
    logic        m_wlast;
    logic        m_wvalid;
    logic        m_wready;
    logic        m_bvalid;
    logic        m_bready;
    int          pass_cnt;
    int          fail_cnt;
    int          proto_err;

    string       rec_name  [64];
    string       rec_port  [64];
    int          rec_wr    [64];
    int          rec_size  [64];
    logic [31:0] rec_vaddr [64];
    logic [31:0] rec_wdata [64];
    logic [31:0] rec_exp   [64];
    int          rec_cach  [64];
    int          rec_par   [64];
    int          nrec;
    int          cycles;
    int          limit;

    logic [31:0] mem [logic [29:0]];   // Word store of the slave

    mem_subsys_top dut (.*);

    tb_checker chk (.*);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Unwritten words read back as the inverted address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2]))
            return mem[addr[31:2]];
        return ~{addr[31:2], 2'b00};
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] wd,
                              input logic [3:0] strb);
        logic [31:0] w;
        w = read_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                w[8*b +: 8] = wd[8*b +: 8];
        end
        mem[addr[31:2]] = w;
    endtask

    // AXI slave, answers one transfer at a time after 0 to 3 idle cycles
    initial begin
        int unsigned delay;
        logic [31:0] rd_word;
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rdata   = 32'h0;
        m_rid     = 4'h0;
        m_awready = 1'b0;
        m_wready  = 1'b0;
        m_bvalid  = 1'b0;
        delay     = 0;
        forever begin
            @(negedge aclk);
            if (rst_n && (m_arvalid || (m_awvalid && m_wvalid))) begin
                if (delay != 0) begin
                    delay = delay - 1;
                end else if (m_arvalid) begin
                    rd_word   = read_word(m_araddr);
                    m_rid     = m_arid;
                    m_arready = 1'b1;
                    @(negedge aclk);
                    m_arready = 1'b0;
                    m_rdata   = rd_word;
                    m_rvalid  = 1'b1;
                    @(negedge aclk);
                    m_rvalid  = 1'b0;
                    delay     = $urandom % 4;
                end else begin
                    write_word(m_awaddr, m_wdata, m_wstrb);
                    m_awready = 1'b1;
                    m_wready  = 1'b1;
                    @(negedge aclk);
                    m_awready = 1'b0;
                    m_wready  = 1'b0;
                    m_bvalid  = 1'b1;
                    @(negedge aclk);
                    m_bvalid  = 1'b0;
                    delay     = $urandom % 4;
                end
            end
        end
    end

    task automatic read_stim();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stim.txt");
            return;
        end
        while (!$feof(fd) && nrec < 64) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%s %s %d %d %h %h %h %d %d", rec_name[nrec],
                              rec_port[nrec], rec_wr[nrec], rec_size[nrec], rec_vaddr[nrec],
                              rec_wdata[nrec], rec_exp[nrec], rec_cach[nrec], rec_par[nrec]);
                if (cnt == 9)
                    nrec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic launch(input int i);
        if (rec_port[i] == "i") begin
            inst_addr = rec_vaddr[i];
            inst_en   = 1'b1;
            chk.expect_req(0, rec_name[i], 1'b0, 2'd2, rec_vaddr[i], 32'h0, rec_exp[i],
                           rec_cach[i] != 0);
        end else begin
            data_wr    = rec_wr[i] != 0;
            data_addr  = rec_vaddr[i];
            data_wdata = rec_wdata[i];
            data_size  = 2'(rec_size[i]);
            data_en    = 1'b1;
            chk.expect_req(1, rec_name[i], rec_wr[i] != 0, 2'(rec_size[i]), rec_vaddr[i],
                           rec_wdata[i], rec_exp[i], rec_cach[i] != 0);
        end
    endtask

    // Enable is held through the response cycle and dropped one edge later
    task automatic wait_done();
        logic i_done;
        logic d_done;
        i_done = 1'b0;
        d_done = 1'b0;
        while (inst_en || data_en) begin
            @(negedge aclk);
            if (i_done)
                inst_en = 1'b0;
            if (d_done)
                data_en = 1'b0;
            if (inst_en && !inst_stall)
                i_done = 1'b1;
            if (data_en && !data_stall)
                d_done = 1'b1;
        end
    endtask

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int idx;
        void'($urandom(22704));
        rst_n      = 1'b0;
        inst_en    = 1'b0;
        inst_addr  = 32'h0;
        data_en    = 1'b0;
        data_wr    = 1'b0;
        data_addr  = 32'h0;
        data_wdata = 32'h0;
        data_size  = 2'd0;
        cycles     = 0;
        limit      = 1000000;
        nrec       = 0;
        read_stim();
        limit = nrec * 20 + 50;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        idx = 0;
        while (idx < nrec) begin
            @(negedge aclk);
            launch(idx);
            if (rec_par[idx] != 0 && idx + 1 < nrec) begin
                launch(idx + 1);   // Fetch and data in the same cycle
                idx++;
            end
            idx++;
            wait_done();
        end
        repeat (4) @(posedge aclk);
        chk.summary();
        if (nrec > 0 && fail_cnt == 0 && proto_err == 0 && pass_cnt == nrec) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
